/* dv/blimp_tb.sv */
// Self-checking testbench for blimp_lite_top
// Expected results come from the instruction word alone, checked in program order
// Retire keeps pace with a one-per-cycle source, so occupancy stays well below rob_depth
`timescale 1ns/1ps

module blimp_tb;

  localparam int directed_count  = 18;         // Tests 2, 3 and 4
  localparam int burst_count     = 40;
  localparam int random_count    = 300;
  localparam int total_count     = directed_count + burst_count + random_count;
  localparam int watchdog_cycles = total_count * 20 + 500;

  logic                  clk;
  logic                  arst_n;
  logic                  inst_val;
  blimp_pkg::inst_word_u inst_word;
  logic                  stall;
  logic                  trace_val;
  logic [31:0]           trace_pc;
  logic [4:0]            trace_waddr;
  logic [31:0]           trace_wdata;
  logic                  trace_wen;

  integer      seed = 32'h9ff5_1db5;
  int          error_count   = 0;
  int          sent_count    = 0;
  int          retired_count = 0;              // Every trace_val strobe
  int          stall_cycles  = 0;
  string       test_name     = "reset";
  logic [31:0] exp_q[$];                       // Sent, not yet traced
  string       name_q[$];                      // Test of each queued word

  blimp_lite_top dut0 (
    .clk, .arst_n, .inst_val, .inst_word, .stall,
    .trace_val, .trace_pc, .trace_waddr, .trace_wdata, .trace_wen
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [32:0] expected_result(input logic [31:0] word);
    logic [1:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    op = word[31:30];
    a  = {20'd0, word[24:13]};                 // opa field
    b  = {20'd0, word[12:1]};                  // opb field
    case (op)
      blimp_pkg::op_add: value = a + b;
      blimp_pkg::op_sub: value = a - b;
      blimp_pkg::op_mul: value = a * b;        // Low 32 bits
      default:           value = {word[24:0], 7'd0};
    endcase
    return {word[29:25] != 5'd0, value};       // {wen, data}
  endfunction

  function automatic logic [31:0] make_arith(input logic [1:0] op, input logic [4:0] rd,
                                             input logic [11:0] a, input logic [11:0] b);
    return {op, rd, a, b, 1'b0};
  endfunction

  function automatic logic [31:0] make_upper(input logic [4:0] rd, input logic [24:0] imm);
    return {blimp_pkg::op_lui, rd, imm};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  // Queue depth bounds the buffer occupancy one edge ahead
  task automatic send_word(input logic [31:0] word);
    @(posedge clk);
    while (stall || exp_q.size() >= blimp_pkg::rob_depth) begin
      inst_val <= 1'b0;
      @(posedge clk);
    end
    inst_val  <= 1'b1;
    inst_word <= word;
    exp_q.push_back(word);
    name_q.push_back(test_name);
    sent_count++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      inst_val <= 1'b0;
    end
  endtask

  // --------------------
  // Trace comparison
  // --------------------
  initial begin : compare_trace
    logic [31:0] word;
    logic [32:0] expected;
    string       name;
    forever begin
      @(negedge clk);                          // Outputs settled
      if (arst_n && stall) stall_cycles++;
      if (arst_n && trace_val) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("ERROR: trace_val at %0t with no instruction outstanding", $time);
        end else begin
          word     = exp_q.pop_front();
          name     = name_q.pop_front();
          expected = expected_result(word);
          compare_value({name, " pc"}, blimp_pkg::reset_pc + 32'(4 * retired_count), trace_pc);
          compare_value({name, " waddr"}, {27'd0, word[29:25]}, {27'd0, trace_waddr});
          compare_value({name, " wdata"}, expected[31:0], trace_wdata);
          compare_value({name, " wen"}, {31'd0, expected[32]}, {31'd0, trace_wen});
        end
        retired_count++;
      end
    end
  end

  // Bounds the run if the trace stops
  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    error_count++;
    $display("ERROR: watchdog expired, the trace stopped with %0d instructions outstanding",
             exp_q.size());
    $display("Checks done: %0d errors, %0d sent, %0d retired",
             error_count, sent_count, retired_count);
    $display("Simulation FAILED");
    $finish;
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin : stimulus
    logic [31:0] word;
    int          gap;
    arst_n    = 1'b0;
    inst_val  = 1'b0;
    inst_word = '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    // Quiet after reset
    test_name = "reset idle";
    repeat (10) begin
      @(negedge clk);
      compare_value("reset idle stall", 32'd0, {31'd0, stall});
      compare_value("reset idle trace_val", 32'd0, {31'd0, trace_val});
    end

    // Each opcode with edge operands
    test_name = "single op";
    send_word(make_arith(blimp_pkg::op_add, 5'd1, 12'd0, 12'd0));
    send_word(make_arith(blimp_pkg::op_add, 5'd2, 12'd4095, 12'd4095));
    send_word(make_arith(blimp_pkg::op_sub, 5'd3, 12'd0, 12'd4095));   // Wraps negative
    send_word(make_arith(blimp_pkg::op_sub, 5'd4, 12'd4095, 12'd0));
    send_word(make_arith(blimp_pkg::op_mul, 5'd5, 12'd4095, 12'd4095));
    send_word(make_arith(blimp_pkg::op_mul, 5'd6, 12'd0, 12'd4095));
    send_word(make_upper(5'd7, 25'd0));
    send_word(make_upper(5'd8, 25'h1ff_ffff));
    send_word(make_upper(5'd9, 25'h0a5_5a5a));
    idle_cycles(10);

    // Adds finish ahead of the mul
    test_name = "mul then adds";
    send_word(make_arith(blimp_pkg::op_mul, 5'd10, 12'd123, 12'd456));
    for (int i = 0; i < 5; i++) begin
      send_word(make_arith(blimp_pkg::op_add, 5'(11 + i), 12'(i), 12'd100));
    end
    idle_cycles(10);

    // x0 destination
    test_name = "rd zero";
    send_word(make_arith(blimp_pkg::op_add, 5'd0, 12'd17, 12'd25));
    send_word(make_arith(blimp_pkg::op_mul, 5'd0, 12'd99, 12'd3));
    send_word(make_upper(5'd0, 25'h123_4567));
    idle_cycles(10);

    test_name = "mul burst";
    for (int i = 0; i < burst_count; i++) begin
      word = {$random(seed)};
      send_word(make_arith(blimp_pkg::op_mul, word[4:0], word[16:5], word[28:17]));
    end
    idle_cycles(20);
    $display("INFO: %0d stall cycles seen so far", stall_cycles);

    test_name = "random";
    for (int i = 0; i < random_count; i++) begin
      word = $random(seed);
      gap  = {$random(seed)} % 4;
      send_word(word);
      if (gap != 0) idle_cycles(gap);
    end
    idle_cycles(1);

    // Drain, then give a stray trace time to show
    while (exp_q.size() != 0) @(posedge clk);
    repeat (5) @(posedge clk);
    compare_value("final retired count", 32'(sent_count), 32'(retired_count));
    $display("Checks done: %0d errors, %0d sent, %0d retired",
             error_count, sent_count, retired_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* hdl/alu_pipe.sv */
// Single-cycle ALU for add, sub and lui
// lui arrives pre-shifted and is executed as an add
`timescale 1ns/1ps

module alu_pipe (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              alu_val,
  input  logic [blimp_pkg::op_bits-1:0]     alu_op,
  input  logic [blimp_pkg::seq_bits-1:0]    alu_seq,
  input  logic [blimp_pkg::reg_bits-1:0]    alu_rd,
  input  logic [blimp_pkg::xlen-1:0]        alu_a,
  input  logic [blimp_pkg::xlen-1:0]        alu_b,
  output logic                              alu_done,
  output logic [blimp_pkg::seq_bits-1:0]    alu_done_seq,
  output logic [blimp_pkg::reg_bits-1:0]    alu_done_rd,
  output logic [blimp_pkg::xlen-1:0]        alu_done_data
);

  logic [blimp_pkg::xlen-1:0] result;

  // Wraps modulo 2^32
  assign result = (alu_op == blimp_pkg::op_sub) ? alu_a - alu_b : alu_a + alu_b;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) alu_done <= 1'b0;
    else         alu_done <= alu_val;
  end

  always_ff @(posedge clk) begin
    if (alu_val) begin
      alu_done_seq  <= alu_seq;
      alu_done_rd   <= alu_rd;
      alu_done_data <= result;
    end
  end

endmodule

/* hdl/blimp_lite_top.sv */
// Issue, two execute pipes, reorder buffer and commit
// Outside must hold inst_val low while stall is high
// Results complete out of order and retire in program order
`timescale 1ns/1ps

module blimp_lite_top (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              inst_val,
  input  blimp_pkg::inst_word_u             inst_word,
  output logic                              stall,
  output logic                              trace_val,
  output logic [blimp_pkg::xlen-1:0]        trace_pc,
  output logic [blimp_pkg::reg_bits-1:0]    trace_waddr,
  output logic [blimp_pkg::xlen-1:0]        trace_wdata,
  output logic                              trace_wen
);

  // --------------------
  // Wires
  // --------------------
  logic [blimp_pkg::seq_bits-1:0] alloc_seq;
  logic                           full;

  logic                           alu_val, mul_val;
  logic [blimp_pkg::op_bits-1:0]  alu_op;
  logic [blimp_pkg::seq_bits-1:0] alu_seq, mul_seq;
  logic [blimp_pkg::reg_bits-1:0] alu_rd, mul_rd;
  logic [blimp_pkg::xlen-1:0]     alu_a, alu_b, mul_a, mul_b;

  logic                           alu_done, mul_done;
  logic [blimp_pkg::seq_bits-1:0] alu_done_seq, mul_done_seq;
  logic [blimp_pkg::reg_bits-1:0] alu_done_rd, mul_done_rd;
  logic [blimp_pkg::xlen-1:0]     alu_done_data, mul_done_data;

  logic                           retire, head_ready;
  logic [blimp_pkg::reg_bits-1:0] head_rd;
  logic [blimp_pkg::xlen-1:0]     head_data;

  assign stall = full;                         // Back-pressure to the source

  // --------------------
  // Units
  // --------------------
  issue_unit issue0 (
    .clk, .arst_n, .inst_val, .inst_word, .alloc_seq,
    .alu_val, .alu_op, .alu_seq, .alu_rd, .alu_a, .alu_b,
    .mul_val, .mul_seq, .mul_rd, .mul_a, .mul_b
  );

  alu_pipe alu0 (
    .clk, .arst_n, .alu_val, .alu_op, .alu_seq, .alu_rd, .alu_a, .alu_b,
    .alu_done, .alu_done_seq, .alu_done_rd, .alu_done_data
  );

  mul_pipe mul0 (
    .clk, .arst_n, .mul_val, .mul_seq, .mul_rd, .mul_a, .mul_b,
    .mul_done, .mul_done_seq, .mul_done_rd, .mul_done_data
  );

  reorder_buffer rob0 (
    .clk, .arst_n,
    .alloc (inst_val),                         // Every strobe takes a slot
    .alloc_seq, .full,
    .alu_done, .alu_done_seq, .alu_done_rd, .alu_done_data,
    .mul_done, .mul_done_seq, .mul_done_rd, .mul_done_data,
    .retire, .head_ready, .head_rd, .head_data
  );

  commit_unit commit0 (
    .clk, .arst_n, .head_ready, .head_rd, .head_data, .retire,
    .trace_val, .trace_pc, .trace_waddr, .trace_wdata, .trace_wen
  );

endmodule

/* hdl/blimp_pkg.sv */
// Shared sizes, opcode encodings and instruction formats
// Sequence numbers wrap at rob_depth, so at most 16 instructions may be in flight
// Operands travel inside the instruction word, so no register file is modeled

package blimp_pkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int seq_bits   = 4;               // Sequence tag width
  localparam int rob_depth  = 16;              // One slot per tag value
  localparam int reg_bits   = 5;               // Destination register address
  localparam int xlen       = 32;              // Data width
  localparam int mul_stages = 4;               // Multiplier latency
  localparam int op_bits    = 2;

  localparam logic [xlen-1:0] reset_pc = 32'h0000_0200;

  // --------------------
  // Opcodes in bits 31:30
  // --------------------
  localparam logic [op_bits-1:0] op_add = 2'd0;
  localparam logic [op_bits-1:0] op_sub = 2'd1;
  localparam logic [op_bits-1:0] op_mul = 2'd2;
  localparam logic [op_bits-1:0] op_lui = 2'd3;

  // Arithmetic format for add, sub and mul
  typedef struct packed {
    logic [op_bits-1:0]  op;
    logic [reg_bits-1:0] rd;
    logic [11:0]         opa;                  // Zero-extended on issue
    logic [11:0]         opb;
    logic                pad;
  } inst_arith_t;

  // Upper format for lui
  typedef struct packed {
    logic [op_bits-1:0]  op;
    logic [reg_bits-1:0] rd;
    logic [24:0]         imm;                  // Lands at bits 31:7
  } inst_upper_t;

  // Same 32-bit word, two readings picked by op
  typedef union packed {
    inst_arith_t arith;
    inst_upper_t upper;
  } inst_word_u;

endpackage

/* hdl/commit_unit.sv */
// In-order retire and instruction trace
// At most one retire per cycle, trace follows on the retire edge
// x0 writes retire with wen low
`timescale 1ns/1ps

module commit_unit (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              head_ready,
  input  logic [blimp_pkg::reg_bits-1:0]    head_rd,
  input  logic [blimp_pkg::xlen-1:0]        head_data,
  output logic                              retire,
  output logic                              trace_val,
  output logic [blimp_pkg::xlen-1:0]        trace_pc,
  output logic [blimp_pkg::reg_bits-1:0]    trace_waddr,
  output logic [blimp_pkg::xlen-1:0]        trace_wdata,
  output logic                              trace_wen
);

  logic [blimp_pkg::xlen-1:0] pc;              // pc of the next retire

  // Head is taken on the next edge whenever it is complete
  assign retire = head_ready;

  // --------------------
  // Retire state
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc        <= blimp_pkg::reset_pc;
      trace_val <= 1'b0;
      trace_wen <= 1'b0;
    end else begin
      trace_val <= retire;                     // One-cycle strobe
      if (retire) begin
        pc        <= pc + 32'd4;
        trace_wen <= head_rd != '0;            // x0 is never written
      end
    end
  end

  // Trace payload, qualified by trace_val
  always_ff @(posedge clk) begin
    if (retire) begin
      trace_pc    <= pc;
      trace_waddr <= head_rd;
      trace_wdata <= head_data;
    end
  end

endmodule

/* hdl/issue_unit.sv */
// Decode and dispatch, one instruction per strobe
// Caller keeps inst_val low while the reorder buffer is full
// Dispatch is registered, so the pipes see it one cycle after acceptance
`timescale 1ns/1ps

module issue_unit (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              inst_val,
  input  blimp_pkg::inst_word_u             inst_word,
  input  logic [blimp_pkg::seq_bits-1:0]    alloc_seq,
  output logic                              alu_val,
  output logic [blimp_pkg::op_bits-1:0]     alu_op,
  output logic [blimp_pkg::seq_bits-1:0]    alu_seq,
  output logic [blimp_pkg::reg_bits-1:0]    alu_rd,
  output logic [blimp_pkg::xlen-1:0]        alu_a,
  output logic [blimp_pkg::xlen-1:0]        alu_b,
  output logic                              mul_val,
  output logic [blimp_pkg::seq_bits-1:0]    mul_seq,
  output logic [blimp_pkg::reg_bits-1:0]    mul_rd,
  output logic [blimp_pkg::xlen-1:0]        mul_a,
  output logic [blimp_pkg::xlen-1:0]        mul_b
);

  logic                       is_mul;
  logic                       is_lui;
  logic [blimp_pkg::xlen-1:0] opa_ext;
  logic [blimp_pkg::xlen-1:0] opb_ext;
  logic [blimp_pkg::xlen-1:0] upper_imm;

  // --------------------
  // Decode
  // --------------------
  assign is_mul = inst_word.arith.op == blimp_pkg::op_mul;
  assign is_lui = inst_word.upper.op == blimp_pkg::op_lui;

  assign opa_ext   = {20'd0, inst_word.arith.opa};  // 12-bit operands
  assign opb_ext   = {20'd0, inst_word.arith.opb};
  assign upper_imm = {inst_word.upper.imm, 7'd0};   // imm << 7

  // Strobes, exactly one per accepted word
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      alu_val <= 1'b0;
      mul_val <= 1'b0;
    end else begin
      alu_val <= inst_val && !is_mul;
      mul_val <= inst_val && is_mul;
    end
  end

  // --------------------
  // Dispatch payload
  // --------------------
  always_ff @(posedge clk) begin
    if (inst_val && !is_mul) begin
      alu_op  <= inst_word.arith.op;
      alu_seq <= alloc_seq;                         // Tag from the tail slot
      alu_rd  <= inst_word.arith.rd;                // Same bits in both formats
      alu_a   <= is_lui ? upper_imm : opa_ext;
      alu_b   <= is_lui ? '0 : opb_ext;             // lui becomes imm + 0
    end
    if (inst_val && is_mul) begin
      mul_seq <= alloc_seq;
      mul_rd  <= inst_word.arith.rd;
      mul_a   <= opa_ext;
      mul_b   <= opb_ext;
    end
  end

endmodule

/* hdl/mul_pipe.sv */
// Pipelined multiplier, low 32 bits of the product only
// Fixed latency of mul_stages cycles, accepts one operation per cycle
// No stall input, results leave the last stage unconditionally
`timescale 1ns/1ps

module mul_pipe (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              mul_val,
  input  logic [blimp_pkg::seq_bits-1:0]    mul_seq,
  input  logic [blimp_pkg::reg_bits-1:0]    mul_rd,
  input  logic [blimp_pkg::xlen-1:0]        mul_a,
  input  logic [blimp_pkg::xlen-1:0]        mul_b,
  output logic                              mul_done,
  output logic [blimp_pkg::seq_bits-1:0]    mul_done_seq,
  output logic [blimp_pkg::reg_bits-1:0]    mul_done_rd,
  output logic [blimp_pkg::xlen-1:0]        mul_done_data
);

  localparam int last = blimp_pkg::mul_stages - 1;

  logic [blimp_pkg::mul_stages-1:0] stg_val;                        // Valid per stage
  logic [blimp_pkg::seq_bits-1:0]   stg_seq  [blimp_pkg::mul_stages];
  logic [blimp_pkg::reg_bits-1:0]   stg_rd   [blimp_pkg::mul_stages];
  logic [blimp_pkg::xlen-1:0]       stg_prod [blimp_pkg::mul_stages];
  logic [blimp_pkg::xlen-1:0]       product;

  assign product = mul_a * mul_b;              // Truncated to xlen

  // --------------------
  // Valid shift chain
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) stg_val <= '0;
    else         stg_val <= {stg_val[last-1:0], mul_val};
  end

  // Tag, destination and product ride along
  always_ff @(posedge clk) begin
    stg_seq[0]  <= mul_seq;
    stg_rd[0]   <= mul_rd;
    stg_prod[0] <= product;                    // Formed in stage 1
    for (int i = 1; i <= last; i++) begin
      stg_seq[i]  <= stg_seq[i-1];
      stg_rd[i]   <= stg_rd[i-1];
      stg_prod[i] <= stg_prod[i-1];
    end
  end

  assign mul_done      = stg_val[last];
  assign mul_done_seq  = stg_seq[last];
  assign mul_done_rd   = stg_rd[last];
  assign mul_done_data = stg_prod[last];

endmodule

/* hdl/reorder_buffer.sv */
// Completion slots indexed by sequence number, retired from the head
// Two write ports, never to the same slot in one cycle
// alloc must stay low while full is high, it is not checked here
`timescale 1ns/1ps

module reorder_buffer (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              alloc,
  output logic [blimp_pkg::seq_bits-1:0]    alloc_seq,
  output logic                              full,
  input  logic                              alu_done,
  input  logic [blimp_pkg::seq_bits-1:0]    alu_done_seq,
  input  logic [blimp_pkg::reg_bits-1:0]    alu_done_rd,
  input  logic [blimp_pkg::xlen-1:0]        alu_done_data,
  input  logic                              mul_done,
  input  logic [blimp_pkg::seq_bits-1:0]    mul_done_seq,
  input  logic [blimp_pkg::reg_bits-1:0]    mul_done_rd,
  input  logic [blimp_pkg::xlen-1:0]        mul_done_data,
  input  logic                              retire,
  output logic                              head_ready,
  output logic [blimp_pkg::reg_bits-1:0]    head_rd,
  output logic [blimp_pkg::xlen-1:0]        head_data
);

  logic [blimp_pkg::seq_bits-1:0]  head;       // Oldest in flight
  logic [blimp_pkg::seq_bits-1:0]  tail;       // Next tag to hand out
  logic [blimp_pkg::seq_bits:0]    count;      // 0 to rob_depth
  logic [blimp_pkg::rob_depth-1:0] done;       // Slot holds a result

  logic [blimp_pkg::reg_bits-1:0]  slot_rd   [blimp_pkg::rob_depth];
  logic [blimp_pkg::xlen-1:0]      slot_data [blimp_pkg::rob_depth];

  // --------------------
  // Status
  // --------------------
  assign alloc_seq  = tail;
  assign full       = count == (blimp_pkg::seq_bits + 1)'(blimp_pkg::rob_depth);
  assign head_ready = done[head];              // Visible right after the write edge
  assign head_rd    = slot_rd[head];
  assign head_data  = slot_data[head];

  // --------------------
  // Pointers and done bits
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end else begin
      if (alloc) begin
        done[tail] <= 1'b0;                    // Fresh slot waits for its pipe
        tail       <= tail + 1'b1;             // Wraps at rob_depth
      end
      if (alu_done) done[alu_done_seq] <= 1'b1;
      if (mul_done) done[mul_done_seq] <= 1'b1;
      if (retire) begin
        // Clear on the way out so an empty buffer never looks ready
        done[head] <= 1'b0;
        head       <= head + 1'b1;
      end
      case ({alloc, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;               // Both or neither
      endcase
    end
  end

  // --------------------
  // Result storage
  // --------------------
  always_ff @(posedge clk) begin
    if (alu_done) begin
      slot_rd[alu_done_seq]   <= alu_done_rd;
      slot_data[alu_done_seq] <= alu_done_data;
    end
    if (mul_done) begin
      slot_rd[mul_done_seq]   <= mul_done_rd;
      slot_data[mul_done_seq] <= mul_done_data;
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the blimp_tb simulation with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -Wno-fatal --top-module blimp_tb \
  -f sources.f -o blimp_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  cat "$build_log"
  echo "Build failed, see $build_log"
  exit 1
fi

./obj_dir/blimp_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation FAILED" "$sim_log"; then
  exit 1
fi
if ! grep -q "Simulation PASSED" "$sim_log"; then
  echo "No pass message in $sim_log"
  exit 1
fi
exit 0

/* sources.f */
hdl/blimp_pkg.sv
hdl/issue_unit.sv
hdl/alu_pipe.sv
hdl/mul_pipe.sv
hdl/reorder_buffer.sv
hdl/commit_unit.sv
hdl/blimp_lite_top.sv
dv/blimp_tb.sv
